// ==== compile.f ====
+incdir+include
hw/cpu_pkg.sv
hw/stage_if.sv
hw/stage_id.sv
hw/forward.sv
hw/stage_ex.sv
hw/stage_mem.sv
hw/cpu.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = cpu_tb
FILELIST = compile.f
OBJDIR = obj_dir
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;

	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] SEED = 32'h1c8a_4290;
	localparam logic [31:0] POISON = 32'hbad0_bad0;
	localparam logic [31:0] POISON_BASE = 32'h0000_0300;
	localparam logic [31:0] POISON_END = 32'h0000_0318;
	localparam logic [31:0] MARKER = 32'h600d_cafe;
	localparam logic [31:0] MARKER_ADDR = 32'h0000_03f0;
	localparam logic [31:0] LOAD_ADDR = 32'h0000_0200;

	localparam logic [5:0] F_ADDU = 6'h21;
	localparam logic [5:0] F_SUBU = 6'h23;
	localparam logic [5:0] F_AND = 6'h24;
	localparam logic [5:0] F_OR = 6'h25;
	localparam logic [5:0] F_XOR = 6'h26;
	localparam logic [5:0] F_SLT = 6'h2a;

	logic clk;
	logic rst;
	logic [31:0] instr_addr;
	logic [31:0] instr_data;
	logic [31:0] dev_mem_addr;
	logic [31:0] dev_mem_data_in;
	logic [31:0] dev_mem_data_out;
	logic dev_mem_req;
	logic dev_mem_is_write;
	logic dev_mem_busy;

	logic [31:0] rom [64];
	logic [31:0] mem [256];
	logic [31:0] model [32];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int rom_len;
	int store_idx;
	bit marker_seen;
	int run_errors = 0;
	int store_errors = 0;
	int protocol_errors = 0;

	cpu i_cpu(.clk(clk), .rst(rst), .instr_addr(instr_addr), .instr_data(instr_data),
		.dev_mem_addr(dev_mem_addr), .dev_mem_data_in(dev_mem_data_in),
		.dev_mem_data_out(dev_mem_data_out), .dev_mem_req(dev_mem_req),
		.dev_mem_is_write(dev_mem_is_write), .dev_mem_busy(dev_mem_busy));

	assign instr_data = rom[instr_addr[7:2]];

	function automatic logic [31:0] encode_rtype(input logic [5:0] funct, input int rd,
		input int rs, input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] encode_jump(input logic [31:0] target);
		return {6'h02, target[27:2]};
	endfunction

	function automatic logic [31:0] alu_expect(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		case (funct)
			F_ADDU: return a + b;
			F_SUBU: return a - b;
			F_AND: return a & b;
			F_OR: return a | b;
			F_XOR: return a ^ b;
			F_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return 32'h0;
		endcase
	endfunction

	// Initial memory contents, different for every word address.
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'h1357_2468;
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[rom_len] = word;
		rom_len++;
	endtask

	task automatic load_const(input int rt, input logic [31:0] value);
		emit(encode_itype(6'h0f, 0, rt, value[31:16]));
		emit(encode_itype(6'h0d, rt, rt, value[15:0]));
		model[rt] = value;
	endtask

	task automatic alu_reg(input logic [5:0] funct, input int rd, input int rs, input int rt);
		emit(encode_rtype(funct, rd, rs, rt));
		model[rd] = alu_expect(funct, model[rs], model[rt]);
	endtask

	task automatic add_imm(input int rt, input int rs, input logic [15:0] imm);
		emit(encode_itype(6'h09, rs, rt, imm));
		model[rt] = model[rs] + {{16{imm[15]}}, imm};
	endtask

	task automatic load_word(input int rt, input logic [31:0] addr);
		emit(encode_itype(6'h23, 0, rt, addr[15:0]));
		model[rt] = fill_word(addr);
	endtask

	task automatic store_word(input int rt, input logic [31:0] addr);
		emit(encode_itype(6'h2b, 0, rt, addr[15:0]));
		exp_addr.push_back(addr);
		exp_data.push_back(model[rt]);
	endtask

	// Register 13 holds the poison word, and these stores must never complete.
	task automatic squashed_store(input logic [31:0] addr);
		emit(encode_itype(6'h2b, 0, 13, addr[15:0]));
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [15:0] imm;
		for (int i = 0; i < 64; i++)
			rom[i] = 32'h0;
		for (int i = 0; i < 32; i++)
			model[i] = 32'h0;
		rom_len = 0;
		a = $urandom;
		b = $urandom;
		c = $urandom;
		imm = 16'($urandom);
		if (b == a)
			b = ~a;
		load_const(1, a);
		load_const(2, b);
		load_const(3, c);
		load_const(13, POISON);
		// Each result feeds the next one or two instructions through forwarding.
		alu_reg(F_ADDU, 4, 1, 2);
		alu_reg(F_SUBU, 5, 4, 3);
		alu_reg(F_AND, 6, 5, 4);
		alu_reg(F_OR, 7, 5, 6);
		alu_reg(F_XOR, 8, 7, 6);
		alu_reg(F_SLT, 9, 7, 8);
		add_imm(10, 9, imm);
		store_word(10, 32'h118);
		store_word(4, 32'h100);
		store_word(5, 32'h104);
		store_word(6, 32'h108);
		store_word(7, 32'h10c);
		store_word(8, 32'h110);
		store_word(9, 32'h114);
		load_word(11, LOAD_ADDR);
		alu_reg(F_ADDU, 12, 11, 3);
		store_word(12, 32'h11c);
		emit(encode_itype(6'h04, 1, 1, 16'd2));
		squashed_store(32'h300);
		squashed_store(32'h304);
		emit(encode_itype(6'h05, 1, 2, 16'd2));
		squashed_store(32'h308);
		squashed_store(32'h30c);
		emit(encode_itype(6'h04, 1, 2, 16'd1));
		store_word(2, 32'h120);
		emit(encode_jump(rom_len * 4 + 12));
		squashed_store(32'h310);
		squashed_store(32'h314);
		load_const(14, MARKER);
		store_word(14, MARKER_ADDR);
		emit(encode_jump(rom_len * 4));
	endtask

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		bit poisoned;
		poisoned = addr >= POISON_BASE && addr < POISON_END;
		assert (!poisoned) else begin
			store_errors++;
			$display("store to squashed address %h completed at %0t", addr, $time);
		end
		assert (poisoned || store_idx < exp_addr.size()) else begin
			store_errors++;
			$display("unexpected extra store to %h at %0t", addr, $time);
		end
		if (!poisoned && store_idx < exp_addr.size()) begin
			assert (addr == exp_addr[store_idx]) else begin
				store_errors++;
				$display("mismatch at %0t: store %0d went to %h, expected %h", $time,
					store_idx, addr, exp_addr[store_idx]);
			end
			assert (data == exp_data[store_idx]) else begin
				store_errors++;
				$display("mismatch at %0t: store to %h wrote %h, expected %h", $time,
					addr, data, exp_data[store_idx]);
			end
			store_idx++;
		end
		if (addr == MARKER_ADDR)
			marker_seen = 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Busy is picked once per request, and accesses are taken at the falling edge.
	initial begin : memory_model
		int busy_left;
		bit pending;
		busy_left = 0;
		pending = 1'b0;
		store_idx = 0;
		marker_seen = 1'b0;
		dev_mem_busy = 1'b0;
		dev_mem_data_in = 32'h0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i * 4);
		forever begin
			@(posedge clk);
			#5;
			if (dev_mem_req === 1'b1) begin
				if (!pending) begin
					busy_left = $urandom_range(2, 0);
					pending = 1'b1;
				end
				dev_mem_busy = busy_left != 0;
				if (busy_left != 0)
					busy_left--;
			end else begin
				dev_mem_busy = 1'b0;
			end
			dev_mem_data_in = mem[dev_mem_addr[9:2]];
			@(negedge clk);
			if (!rst && dev_mem_req === 1'b1 && !dev_mem_busy) begin
				if (dev_mem_is_write) begin
					mem[dev_mem_addr[9:2]] = dev_mem_data_out;
					check_store(dev_mem_addr, dev_mem_data_out);
				end
				pending = 1'b0;
			end
		end
	end

	reset_idle: assert property (@(posedge clk) rst |=> !dev_mem_req && !dev_mem_is_write)
		else begin
			protocol_errors++;
			$display("data port active during reset at %0t", $time);
		end

	reset_state: assert property (@(posedge clk) $fell(rst) |->
		instr_addr == `RESET_PC && !dev_mem_req && !dev_mem_is_write)
		else begin
			protocol_errors++;
			$display("mismatch at %0t: fetch address or data port wrong after reset", $time);
		end

	busy_hold: assert property (@(posedge clk) disable iff (rst)
		dev_mem_req && dev_mem_busy |=> dev_mem_req && $stable(dev_mem_addr)
		&& $stable(dev_mem_data_out) && $stable(dev_mem_is_write) && $stable(instr_addr))
		else begin
			protocol_errors++;
			$display("mismatch at %0t: request or fetch moved while memory was busy", $time);
		end

	initial begin : main
		int cycles;
		void'($urandom(SEED));
		rst = 1'b1;
		build_program();
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		cycles = 0;
		while (!marker_seen && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		assert (marker_seen) else begin
			run_errors++;
			$display("timeout: no end marker stored within %0d cycles", MAX_CYCLES);
		end
		assert (store_idx == exp_addr.size()) else begin
			run_errors++;
			$display("only %0d of %0d expected stores completed", store_idx, exp_addr.size());
		end
		$display("run errors %0d, store errors %0d, protocol errors %0d",
			run_errors, store_errors, protocol_errors);
		if (run_errors + store_errors + protocol_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu(
	input logic clk,
	input logic rst,
	output logic [31:0] instr_addr,
	input logic [31:0] instr_data,
	output logic [31:0] dev_mem_addr,
	input logic [31:0] dev_mem_data_in,
	output logic [31:0] dev_mem_data_out,
	output logic dev_mem_req,
	output logic dev_mem_is_write,
	input logic dev_mem_busy);

	logic stall;
	logic clear;
	logic bubble;
	logic [31:0] branch_dest;

	logic [31:0] if_instr;
	logic [31:0] if_pc;
	logic if_valid;

	logic [`REG_ADDR_WIDTH-1:0] src_addr [`NUM_FWD_SRC];
	logic [31:0] src_data [`NUM_FWD_SRC];
	logic [31:0] fwd_data [`NUM_FWD_SRC];
	cpu_pkg::alu_op_t id_alu_op;
	cpu_pkg::mem_op_t id_mem_op;
	cpu_pkg::branch_op_t id_branch_op;
	logic [31:0] id_imm;
	logic id_use_imm;
	logic [`REG_ADDR_WIDTH-1:0] id_dest;
	logic [31:0] id_pc;
	logic [31:0] id_target;
	logic id_valid;

	logic [31:0] ex_result;
	logic [31:0] ex_store_data;
	logic [`REG_ADDR_WIDTH-1:0] ex_dest;
	logic ex_from_alu;
	cpu_pkg::mem_op_t ex_mem_op;

	logic [`REG_ADDR_WIDTH-1:0] wb_addr;
	logic [31:0] wb_data;
	logic wb_en;

	stage_if i_if(.clk(clk), .rst(rst), .stall(stall), .clear(clear),
		.bubble(bubble), .branch_dest(branch_dest),
		.instr_addr(instr_addr), .instr_data(instr_data),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid));

	stage_id i_id(.clk(clk), .rst(rst), .stall(stall), .clear(clear),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid),
		.wb_addr(wb_addr), .wb_data(wb_data), .wb_en(wb_en),
		.bubble(bubble), .src_addr(src_addr), .src_data(src_data),
		.id_alu_op(id_alu_op), .id_mem_op(id_mem_op), .id_branch_op(id_branch_op),
		.id_imm(id_imm), .id_use_imm(id_use_imm), .id_dest(id_dest),
		.id_pc(id_pc), .id_target(id_target), .id_valid(id_valid));

	// One forwarding unit per source operand, rs first.
	for (genvar i = 0; i < `NUM_FWD_SRC; i++) begin : g_fwd
		forward i_fwd(.src_addr(src_addr[i]), .src_data(src_data[i]),
			.ex_dest(ex_dest), .ex_result(ex_result), .ex_from_alu(ex_from_alu),
			.wb_addr(wb_addr), .wb_data(wb_data), .wb_en(wb_en),
			.fwd_data(fwd_data[i]));
	end

	stage_ex i_ex(.clk(clk), .rst(rst), .stall(stall), .clear(clear),
		.id_alu_op(id_alu_op), .id_mem_op(id_mem_op), .id_branch_op(id_branch_op),
		.id_imm(id_imm), .id_use_imm(id_use_imm), .id_dest(id_dest),
		.id_pc(id_pc), .id_target(id_target), .id_valid(id_valid),
		.fwd_data(fwd_data), .branch_flag(clear), .branch_dest(branch_dest),
		.ex_result(ex_result), .ex_store_data(ex_store_data), .ex_dest(ex_dest),
		.ex_from_alu(ex_from_alu), .ex_mem_op(ex_mem_op));

	stage_mem i_mem(.clk(clk), .rst(rst),
		.ex_result(ex_result), .ex_store_data(ex_store_data), .ex_dest(ex_dest),
		.ex_mem_op(ex_mem_op), .ex_from_alu(ex_from_alu), .stall(stall),
		.dev_mem_addr(dev_mem_addr), .dev_mem_data_out(dev_mem_data_out),
		.dev_mem_req(dev_mem_req), .dev_mem_is_write(dev_mem_is_write),
		.dev_mem_data_in(dev_mem_data_in), .dev_mem_busy(dev_mem_busy),
		.wb_addr(wb_addr), .wb_data(wb_data), .wb_en(wb_en));

endmodule

`default_nettype wire

// ==== hw/stage_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module stage_mem(
	input logic clk,
	input logic rst,
	input logic [31:0] ex_result,
	input logic [31:0] ex_store_data,
	input logic [`REG_ADDR_WIDTH-1:0] ex_dest,
	input cpu_pkg::mem_op_t ex_mem_op,
	input logic ex_from_alu,
	output logic stall,
	output logic [31:0] dev_mem_addr,
	output logic [31:0] dev_mem_data_out,
	output logic dev_mem_req,
	output logic dev_mem_is_write,
	input logic [31:0] dev_mem_data_in,
	input logic dev_mem_busy,
	output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	output logic [31:0] wb_data,
	output logic wb_en);

	logic is_load;

	assign is_load = ex_mem_op == cpu_pkg::MEM_LOAD;

	// The request stays up, unchanged, until the device drops busy.
	assign dev_mem_req = ex_mem_op != cpu_pkg::MEM_NONE;
	assign dev_mem_is_write = ex_mem_op == cpu_pkg::MEM_STORE;
	assign dev_mem_addr = ex_result;
	assign dev_mem_data_out = ex_store_data;

	assign stall = dev_mem_req && dev_mem_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en <= 1'b0;
			wb_addr <= '0;
		end else if (!stall) begin
			wb_en <= ex_from_alu || (is_load && ex_dest != '0);
			wb_addr <= ex_dest;
		end
	end

	// The load word is taken in the cycle the access completes.
	always_ff @(posedge clk) begin
		if (!stall)
			wb_data <= ex_from_alu ? ex_result : dev_mem_data_in;
	end

endmodule

`default_nettype wire

// ==== hw/stage_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module stage_ex(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic clear,
	input cpu_pkg::alu_op_t id_alu_op,
	input cpu_pkg::mem_op_t id_mem_op,
	input cpu_pkg::branch_op_t id_branch_op,
	input logic [31:0] id_imm,
	input logic id_use_imm,
	input logic [`REG_ADDR_WIDTH-1:0] id_dest,
	input logic [31:0] id_pc,
	input logic [31:0] id_target,
	input logic id_valid,
	input logic [31:0] fwd_data [`NUM_FWD_SRC],
	output logic branch_flag,
	output logic [31:0] branch_dest,
	output logic [31:0] ex_result,
	output logic [31:0] ex_store_data,
	output logic [`REG_ADDR_WIDTH-1:0] ex_dest,
	output logic ex_from_alu,
	output cpu_pkg::mem_op_t ex_mem_op);

	logic [31:0] opa;
	logic [31:0] opb;
	logic [31:0] alu_result;
	logic [31:0] branch_target;
	logic taken;

	assign opa = fwd_data[0];
	assign opb = id_use_imm ? id_imm : fwd_data[1];

	always_comb begin
		case (id_alu_op)
			cpu_pkg::ALU_SUB: alu_result = opa - opb;
			cpu_pkg::ALU_AND: alu_result = opa & opb;
			cpu_pkg::ALU_OR: alu_result = opa | opb;
			cpu_pkg::ALU_XOR: alu_result = opa ^ opb;
			cpu_pkg::ALU_SLT: alu_result = {31'b0, $signed(opa) < $signed(opb)};
			cpu_pkg::ALU_LUI: alu_result = {opb[15:0], 16'h0000};
			default: alu_result = opa + opb;
		endcase
	end

	always_comb begin
		case (id_branch_op)
			cpu_pkg::BR_BEQ: taken = fwd_data[0] == fwd_data[1];
			cpu_pkg::BR_BNE: taken = fwd_data[0] != fwd_data[1];
			cpu_pkg::BR_J: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// These follow the decode-to-execute register, so they hold while stalled.
	assign branch_flag = id_valid && taken;
	assign branch_target = id_pc + 32'd4 + {id_imm[29:0], 2'b00};
	assign branch_dest = (id_branch_op == cpu_pkg::BR_J) ? id_target : branch_target;

	// A taken branch writes nothing, so it moves on as a bubble.
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_dest <= '0;
			ex_from_alu <= 1'b0;
			ex_mem_op <= cpu_pkg::MEM_NONE;
		end else if (!stall) begin
			if (clear) begin
				ex_dest <= '0;
				ex_from_alu <= 1'b0;
				ex_mem_op <= cpu_pkg::MEM_NONE;
			end else begin
				ex_dest <= id_dest;
				ex_from_alu <= id_mem_op == cpu_pkg::MEM_NONE && id_dest != '0;
				ex_mem_op <= id_mem_op;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_result <= alu_result;
			ex_store_data <= fwd_data[1];
		end
	end

endmodule

`default_nettype wire

// ==== hw/forward.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module forward(
	input logic [`REG_ADDR_WIDTH-1:0] src_addr,
	input logic [31:0] src_data,
	input logic [`REG_ADDR_WIDTH-1:0] ex_dest,
	input logic [31:0] ex_result,
	input logic ex_from_alu,
	input logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	input logic [31:0] wb_data,
	input logic wb_en,
	output logic [31:0] fwd_data);

	// The memory stage holds the newer value, so it is checked before write-back.
	always_comb begin
		fwd_data = src_data;
		if (src_addr != '0) begin
			if (ex_from_alu && ex_dest == src_addr)
				fwd_data = ex_result;
			else if (wb_en && wb_addr == src_addr)
				fwd_data = wb_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/stage_id.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module stage_id(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic clear,
	input logic [31:0] if_instr,
	input logic [31:0] if_pc,
	input logic if_valid,
	input logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	input logic [31:0] wb_data,
	input logic wb_en,
	output logic bubble,
	output logic [`REG_ADDR_WIDTH-1:0] src_addr [`NUM_FWD_SRC],
	output logic [31:0] src_data [`NUM_FWD_SRC],
	output cpu_pkg::alu_op_t id_alu_op,
	output cpu_pkg::mem_op_t id_mem_op,
	output cpu_pkg::branch_op_t id_branch_op,
	output logic [31:0] id_imm,
	output logic id_use_imm,
	output logic [`REG_ADDR_WIDTH-1:0] id_dest,
	output logic [31:0] id_pc,
	output logic [31:0] id_target,
	output logic id_valid);

	logic [31:0] regs [32];

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [`REG_ADDR_WIDTH-1:0] rs;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic [`REG_ADDR_WIDTH-1:0] rd;
	logic [`REG_ADDR_WIDTH-1:0] src_field [`NUM_FWD_SRC];
	logic [31:0] pc_plus4;

	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::mem_op_t mem_op;
	cpu_pkg::branch_op_t branch_op;
	logic [31:0] imm;
	logic use_imm;
	logic [`REG_ADDR_WIDTH-1:0] dest;
	logic uses_rs;
	logic uses_rt;

	assign opcode = if_instr[31:26];
	assign funct = if_instr[5:0];
	assign rs = if_instr[25:21];
	assign rt = if_instr[20:16];
	assign rd = if_instr[15:11];
	assign src_field = '{rs, rt};
	assign pc_plus4 = if_pc + 32'd4;

	// Register zero reads as zero, and a write in the same cycle is seen at once.
	function automatic logic [31:0] read_reg(input logic [`REG_ADDR_WIDTH-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb_en && wb_addr == addr)
			return wb_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb_en && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	// Unknown encodings decode as a nop with no destination.
	always_comb begin
		alu_op = cpu_pkg::ALU_ADD;
		mem_op = cpu_pkg::MEM_NONE;
		branch_op = cpu_pkg::BR_NONE;
		imm = {{16{if_instr[15]}}, if_instr[15:0]};
		use_imm = 1'b1;
		dest = rt;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		case (opcode)
			6'h00: begin
				use_imm = 1'b0;
				dest = rd;
				uses_rt = 1'b1;
				case (funct)
					6'h21: alu_op = cpu_pkg::ALU_ADD;
					6'h23: alu_op = cpu_pkg::ALU_SUB;
					6'h24: alu_op = cpu_pkg::ALU_AND;
					6'h25: alu_op = cpu_pkg::ALU_OR;
					6'h26: alu_op = cpu_pkg::ALU_XOR;
					6'h2a: alu_op = cpu_pkg::ALU_SLT;
					default: dest = '0;
				endcase
			end
			6'h09: alu_op = cpu_pkg::ALU_ADD;
			6'h0d: begin
				alu_op = cpu_pkg::ALU_OR;
				imm = {16'h0000, if_instr[15:0]};
			end
			6'h0f: begin
				alu_op = cpu_pkg::ALU_LUI;
				imm = {16'h0000, if_instr[15:0]};
				uses_rs = 1'b0;
			end
			6'h23: mem_op = cpu_pkg::MEM_LOAD;
			6'h2b: begin
				mem_op = cpu_pkg::MEM_STORE;
				dest = '0;
				uses_rt = 1'b1;
			end
			6'h04, 6'h05: begin
				branch_op = (opcode == 6'h04) ? cpu_pkg::BR_BEQ : cpu_pkg::BR_BNE;
				use_imm = 1'b0;
				dest = '0;
				uses_rt = 1'b1;
			end
			6'h02: begin
				branch_op = cpu_pkg::BR_J;
				dest = '0;
				uses_rs = 1'b0;
			end
			default: begin
				dest = '0;
				uses_rs = 1'b0;
			end
		endcase
	end

	// A load in execute cannot forward its word yet, so hold the consumer one cycle.
	assign bubble = id_valid && id_mem_op == cpu_pkg::MEM_LOAD && id_dest != '0 && if_valid
		&& ((uses_rs && rs == id_dest) || (uses_rt && rt == id_dest));

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
			id_mem_op <= cpu_pkg::MEM_NONE;
			id_branch_op <= cpu_pkg::BR_NONE;
			id_dest <= '0;
			src_addr <= '{default: '0};
		end else if (!stall) begin
			if (clear || bubble || !if_valid) begin
				id_valid <= 1'b0;
				id_mem_op <= cpu_pkg::MEM_NONE;
				id_branch_op <= cpu_pkg::BR_NONE;
				id_dest <= '0;
				src_addr <= '{default: '0};
			end else begin
				id_valid <= 1'b1;
				id_mem_op <= mem_op;
				id_branch_op <= branch_op;
				id_dest <= dest;
				src_addr <= src_field;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			for (int i = 0; i < `NUM_FWD_SRC; i++)
				src_data[i] <= read_reg(src_field[i]);
			id_alu_op <= alu_op;
			id_imm <= imm;
			id_use_imm <= use_imm;
			id_pc <= if_pc;
			id_target <= {pc_plus4[31:28], if_instr[25:0], 2'b00};
		end
	end

endmodule

`default_nettype wire

// ==== hw/stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module stage_if(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic clear,
	input logic bubble,
	input logic [31:0] branch_dest,
	output logic [31:0] instr_addr,
	input logic [31:0] instr_data,
	output logic [31:0] if_instr,
	output logic [31:0] if_pc,
	output logic if_valid);

	logic [31:0] pc;

	assign instr_addr = pc;

	// Stall wins over a redirect, and a redirect wins over a load-use hold.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			if_valid <= 1'b0;
		end else if (!stall) begin
			if (clear) begin
				pc <= branch_dest;
				if_valid <= 1'b0;
			end else if (!bubble) begin
				pc <= pc + 32'd4;
				if_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !clear && !bubble) begin
			if_instr <= instr_data;
			if_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Operation performed by the execute stage ALU.
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// What the memory stage does with the instruction.
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_t;

	// Control-flow kind, resolved in execute.
	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_J
	} branch_op_t;

endpackage

`default_nettype wire

// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of a register number in an instruction word.
`define REG_ADDR_WIDTH 5

// First instruction address after reset.
`define RESET_PC 32'h0000_0000

// Source operands that go through a forwarding unit, rs and rt.
`define NUM_FWD_SRC 2

`endif
